//--- pe_tile.f
+incdir+include
rtl/cgra_pkg.sv
rtl/connect_box.sv
rtl/logic_block.sv
rtl/switch_box.sv
rtl/pe_tile.sv
verification/tb_clock.sv
verification/pe_tile_tb.sv

//--- Makefile
TOP := pe_tile_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f pe_tile.f

run: compile
	./obj_dir/V$(TOP) > run.log 2>&1; cat run.log
	grep -q -F "*** TEST PASSED ***" run.log

clean:
	rm -rf obj_dir run.log

//--- verification/pe_tile_tb.sv
`include "cgra_params.svh"

module pe_tile_tb
   import cgra_pkg::*;
();

   localparam logic [`TILE_ID_W-1:0] TILE_ID = 16'h00a5;
   localparam int                    WAIT_LIMIT = 20;

   logic                  clk;
   logic                  arst_n;
   config_addr_t          config_addr;
   config_word_u          config_data;
   logic [`TILE_ID_W-1:0] tile_id;
   tile_tracks_t          tracks_in;
   tile_tracks_t          tracks_out;

   // Reference model state
   logic [`SEL_W-1:0]    model_route [`NUM_SIDES][`NUM_TRACKS];
   logic [`SEL_W-1:0]    model_cb_sel [2];
   logic [`LUT_SIZE-1:0] model_lut;
   logic                 model_reg;
   logic                 model_q;
   logic                 model_lut_value;
   logic                 model_result;
   logic [15:0]          expected_out;

   logic  check_en;
   string test_name;
   int    check_count;
   int    error_count;
   int    test_checks;
   int    test_errors;

   tb_clock #(.PERIOD(10), .RESET_CYCLES(4)) clock_gen (
      .clk    (clk),
      .arst_n (arst_n)
   );

   pe_tile pe_tile_inst (
      .clk         (clk),
      .arst_n      (arst_n),
      .config_addr (config_addr),
      .config_data (config_data),
      .tile_id     (tile_id),
      .tracks_in   (tracks_in),
      .tracks_out  (tracks_out)
   );

   // ####################
   // Reference model
   // ####################
   always_comb begin
      logic [15:0] in_vec;
      in_vec = tracks_in;
      model_lut_value = model_lut[{in_vec[`NUM_TRACKS + model_cb_sel[1]],
                                   in_vec[model_cb_sel[0]]}];
      model_result = model_reg ? model_q : model_lut_value;
      for (int s = 0; s < `NUM_SIDES; s++) begin
         for (int t = 0; t < `NUM_TRACKS; t++) begin
            if (model_route[s][t] == `SEL_W'(`SEL_CLB)) begin
               expected_out[s*`NUM_TRACKS + t] = model_result;
            end else begin
               expected_out[s*`NUM_TRACKS + t] =
                  in_vec[((s + int'(model_route[s][t]) + 1) % `NUM_SIDES) * `NUM_TRACKS + t];
            end
         end
      end
   end

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         model_q <= 1'b0;
      end else begin
         model_q <= model_lut_value;                 // Last cycle's lookup
      end
   end

   a_tracks_out: assert property (
      @(posedge clk) disable iff (!arst_n || !check_en)
      tracks_out == expected_out
   ) check_count++;
   else report_mismatch($sampled(expected_out), $sampled(tracks_out));

   // ####################
   // Helpers
   // ####################
   task automatic report_mismatch(input logic [15:0] expected, input logic [15:0] actual);
      error_count++;
      $display("Mismatch in %s: expected %h, actual %h", test_name, expected, actual);
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic update_model(input logic [15:0] feature, input logic [31:0] word);
      case (feature)
         16'(`FEAT_CB0): model_cb_sel[0] = word[1:0];
         16'(`FEAT_CB1): model_cb_sel[1] = word[1:0];
         16'(`FEAT_SB): begin
            for (int s = 0; s < `NUM_SIDES; s++) begin
               for (int t = 0; t < `NUM_TRACKS; t++) begin
                  model_route[s][t] = word[(s*`NUM_TRACKS + t)*2 +: 2];
               end
            end
         end
         16'(`FEAT_CLB): begin
            model_lut = word[3:0];
            model_reg = word[4];
         end
         default: ;                                    // Idle code
      endcase
   endtask

   // One cycle on the config bus, then back to idle
   task automatic config_write(input logic [15:0] feature, input logic [15:0] id,
                               input logic [31:0] word);
      config_addr = {feature, id};
      config_data = word;
      next_cycle();
      config_addr = '0;
      config_data = '0;
      if (id == tile_id) begin
         update_model(feature, word);
      end
   endtask

   function automatic logic [31:0] random_route_word();
      logic [31:0] word;
      word = '0;
      for (int i = 0; i < `NUM_SIDES * `NUM_TRACKS; i++) begin
         word[i*2 +: 2] = 2'($urandom % 3);            // Never the clb select
      end
      return word;
   endfunction

   // Random tracks with the chosen operand pair on the selected tracks
   function automatic tile_tracks_t tracks_for_pair(input logic [1:0] pair);
      logic [15:0] vec;
      vec = 16'($urandom);
      vec[model_cb_sel[0]] = pair[0];
      vec[`NUM_TRACKS + model_cb_sel[1]] = pair[1];
      return vec;
   endfunction

   task automatic check_now(input logic [15:0] expected);
      @(negedge clk);
      check_count++;
      a_now: assert (tracks_out == expected)
         else report_mismatch(expected, tracks_out);
      next_cycle();
   endtask

   task automatic wait_reset_release(output bit released);
      int cycles;
      cycles = 0;
      while (arst_n !== 1'b1 && cycles < WAIT_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      released = (arst_n === 1'b1);
      if (released) begin
         next_cycle();
      end
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_checks = check_count;
      test_errors = error_count;
   endtask

   task automatic finish_test();
      $display("%-16s checks %0d, errors %0d", test_name,
               check_count - test_checks, error_count - test_errors);
   endtask

   // ####################
   // Tests
   // ####################
   task automatic reset_defaults();
      start_test("reset_defaults");
      for (int i = 0; i < 20; i++) begin
         tracks_in = 16'($urandom);
         next_cycle();
      end
      finish_test();
   endtask

   task automatic sb_routing();
      start_test("sb_routing");
      for (int n = 0; n < 8; n++) begin
         config_write(16'(`FEAT_SB), tile_id, random_route_word());
         for (int i = 0; i < 6; i++) begin
            tracks_in = 16'($urandom);
            next_cycle();
         end
      end
      finish_test();
   endtask

   task automatic lut_comb();
      logic [3:0] lut;
      start_test("lut_comb");
      lut = 4'($urandom);
      config_write(16'(`FEAT_CB0), tile_id, 32'($urandom % 4));
      config_write(16'(`FEAT_CB1), tile_id, 32'($urandom % 4));
      config_write(16'(`FEAT_CLB), tile_id, {27'b0, 1'b0, lut});
      config_write(16'(`FEAT_SB), tile_id, {16{2'(`SEL_CLB)}});
      for (int p = 0; p < 4; p++) begin
         tracks_in = tracks_for_pair(2'(p));
         check_now({16{lut[p]}});                     // Same cycle
      end
      finish_test();
   endtask

   task automatic lut_registered();
      logic [3:0] lut;
      logic [1:0] pair;
      logic [1:0] prev_pair;
      start_test("lut_registered");
      lut = 4'($urandom);
      config_write(16'(`FEAT_CLB), tile_id, {27'b0, 1'b1, lut});
      prev_pair = 2'($urandom);
      tracks_in = tracks_for_pair(prev_pair);
      next_cycle();
      for (int i = 0; i < 12; i++) begin
         pair = 2'($urandom);
         tracks_in = tracks_for_pair(pair);
         check_now({16{lut[prev_pair]}});
         prev_pair = pair;
      end
      finish_test();
   endtask

   task automatic tile_filter();
      logic [15:0] snapshot;
      start_test("tile_filter");
      config_write(16'(`FEAT_SB), tile_id, random_route_word());
      tracks_in = 16'($urandom);
      @(negedge clk);
      snapshot = expected_out;
      next_cycle();
      config_write(16'(`FEAT_SB), tile_id ^ 16'h0001, random_route_word());
      config_write(16'(`FEAT_SB), tile_id + 16'h0100, random_route_word());
      config_write(16'd0, tile_id, random_route_word());   // Idle code
      config_write(16'(`FEAT_CB0), tile_id ^ 16'h8000, 32'h3);
      check_now(snapshot);
      for (int i = 0; i < 8; i++) begin
         tracks_in = 16'($urandom);
         next_cycle();
      end
      finish_test();
   endtask

   // ####################
   // Main sequence
   // ####################
   initial begin
      bit released;
      void'($urandom(72710));
      config_addr = '0;
      config_data = '0;
      tile_id     = TILE_ID;
      tracks_in   = '0;
      check_en    = 1'b0;
      check_count = 0;
      error_count = 0;
      test_name   = "init";
      for (int s = 0; s < `NUM_SIDES; s++) begin
         for (int t = 0; t < `NUM_TRACKS; t++) begin
            model_route[s][t] = '0;
         end
      end
      model_cb_sel[0] = '0;
      model_cb_sel[1] = '0;
      model_lut       = '0;
      model_reg       = 1'b0;

      wait_reset_release(released);
      if (!released) begin
         $display("Reset was not released within %0d cycles", WAIT_LIMIT);
         $display("*** TEST FAILED ***");
      end else begin
         check_en = 1'b1;
         reset_defaults();
         sb_routing();
         lut_comb();
         lut_registered();
         tile_filter();
         check_en = 1'b0;

         $display("Total: %0d checks, %0d errors", check_count, error_count);
         if (error_count == 0) begin
            $display("*** TEST PASSED ***");
         end else begin
            $display("*** TEST FAILED ***");
         end
      end
      $finish;
   end

endmodule

//--- verification/tb_clock.sv
module tb_clock #(
   parameter int PERIOD       = 10,
   parameter int RESET_CYCLES = 4
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // Release just after an edge
   initial begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 arst_n = 1'b1;
   end

endmodule

//--- rtl/pe_tile.sv
`include "cgra_params.svh"

module pe_tile
   import cgra_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n,

   input  config_addr_t          config_addr,
   input  config_word_u          config_data,

   input  logic [`TILE_ID_W-1:0] tile_id,

   input  tile_tracks_t          tracks_in,
   output tile_tracks_t          tracks_out
);

   logic operand0;
   logic operand1;
   logic clb_result;

   logic config_this_tile;
   logic config_en_cb0;
   logic config_en_cb1;
   logic config_en_sb;
   logic config_en_clb;

   // ####################
   // Address decode
   // ####################
   assign config_this_tile = (config_addr.tile == tile_id);

   // Feature code 0 and unknown codes fall through as idle
   assign config_en_cb0 = config_this_tile &&
                          (config_addr.feature == `TILE_ID_W'(`FEAT_CB0));
   assign config_en_cb1 = config_this_tile &&
                          (config_addr.feature == `TILE_ID_W'(`FEAT_CB1));
   assign config_en_sb  = config_this_tile &&
                          (config_addr.feature == `TILE_ID_W'(`FEAT_SB));
   assign config_en_clb = config_this_tile &&
                          (config_addr.feature == `TILE_ID_W'(`FEAT_CLB));

   a_one_target: assert property (
      @(posedge clk) disable iff (!arst_n)
      $onehot0({config_en_cb0, config_en_cb1, config_en_sb, config_en_clb})
   ) else $error("pe_tile: more than one config target enabled");

   // ####################
   // Blocks
   // ####################
   connect_box cb0 (
      .clk         (clk),
      .arst_n      (arst_n),
      .config_en   (config_en_cb0),
      .config_data (config_data),
      .tracks      (tracks_in.side0),
      .operand     (operand0)
   );

   connect_box cb1 (
      .clk         (clk),
      .arst_n      (arst_n),
      .config_en   (config_en_cb1),
      .config_data (config_data),
      .tracks      (tracks_in.side1),
      .operand     (operand1)
   );

   logic_block clb (
      .clk         (clk),
      .arst_n      (arst_n),
      .config_en   (config_en_clb),
      .config_data (config_data),
      .operand0    (operand0),
      .operand1    (operand1),
      .result      (clb_result)
   );

   // Sole driver of the output tracks
   switch_box sb (
      .clk         (clk),
      .arst_n      (arst_n),
      .config_en   (config_en_sb),
      .config_data (config_data),
      .tracks_in   (tracks_in),
      .clb_result  (clb_result),
      .tracks_out  (tracks_out)
   );

endmodule

//--- rtl/switch_box.sv
`include "cgra_params.svh"

module switch_box
   import cgra_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n,

   input  logic         config_en,
   input  config_word_u config_data,

   input  tile_tracks_t tracks_in,
   input  logic         clb_result,
   output tile_tracks_t tracks_out
);

   // Route selects, [side][track]
   logic [`NUM_SIDES-1:0][`NUM_TRACKS-1:0][`SEL_W-1:0] route_sel;

   logic [`NUM_SIDES-1:0][`NUM_TRACKS-1:0] in_vec;
   logic [`NUM_SIDES-1:0][`NUM_TRACKS-1:0] out_vec;

   // ####################
   // Route registers
   // ####################
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         route_sel <= '0;                     // Each output copies next side
      end else if (config_en) begin
         route_sel <= config_data.sb_cfg.route;
      end
   end

   assign in_vec = tracks_in;

   // ####################
   // Output muxes
   // ####################
   // Select k picks side (s+k+1) mod 4, same track
   always_comb begin
      for (int s = 0; s < `NUM_SIDES; s++) begin
         for (int t = 0; t < `NUM_TRACKS; t++) begin
            if (route_sel[s][t] == `SEL_W'(`SEL_CLB)) begin
               out_vec[s][t] = clb_result;
            end else begin
               out_vec[s][t] = in_vec[(s + int'(route_sel[s][t]) + 1) % `NUM_SIDES][t];
            end
         end
      end
   end

   assign tracks_out = tile_tracks_t'(out_vec);

   // Logic block result reaches the tile edge
   for (genvar gs = 0; gs < `NUM_SIDES; gs++) begin : g_side
      for (genvar gt = 0; gt < `NUM_TRACKS; gt++) begin : g_track
         a_clb_route: assert property (
            @(posedge clk) disable iff (!arst_n)
            (route_sel[gs][gt] == `SEL_W'(`SEL_CLB)) |->
               (tracks_out[gs*`NUM_TRACKS + gt] == clb_result)
         ) else $error("switch_box: side %0d track %0d lost clb result", gs, gt);
      end
   end

endmodule

//--- rtl/logic_block.sv
`include "cgra_params.svh"

module logic_block
   import cgra_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n,

   input  logic         config_en,
   input  config_word_u config_data,

   input  logic         operand0,
   input  logic         operand1,
   output logic         result
);

   logic [`LUT_SIZE-1:0] lut;
   logic                 reg_mode;
   logic                 lut_value;
   logic                 result_q;

   // ####################
   // Configuration
   // ####################
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         lut      <= '0;
         reg_mode <= 1'b0;
      end else if (config_en) begin
         lut      <= config_data.clb_cfg.lut;
         reg_mode <= config_data.clb_cfg.reg_en;
      end
   end

   // Table lookup
   assign lut_value = lut[{operand1, operand0}];

   // ####################
   // Output register
   // ####################
   // Captures every cycle, so switching mode needs no warm-up
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         result_q <= 1'b0;
      end else begin
         result_q <= lut_value;
      end
   end

   assign result = reg_mode ? result_q : lut_value;

   // Registered mode shows last cycle's lookup
   a_reg_mode: assert property (
      @(posedge clk) disable iff (!arst_n)
      reg_mode |-> (result == $past(lut_value))
   ) else $error("logic_block: registered result differs from past lookup");

endmodule

//--- rtl/connect_box.sv
`include "cgra_params.svh"

module connect_box
   import cgra_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n,

   input  logic         config_en,
   input  config_word_u config_data,

   input  side_tracks_t tracks,
   output logic         operand
);

   logic [`SEL_W-1:0]      track_sel;
   logic [`NUM_TRACKS-1:0] track_vec;

   // ####################
   // Select register
   // ####################
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         track_sel <= '0;
      end else if (config_en) begin
         track_sel <= config_data.cb_cfg.track_sel;
      end
   end

   assign track_vec = tracks;                 // track0 lands on bit 0

   // Only the switch box drives the tracks
   assign operand = track_vec[track_sel];

   // Known tracks give a known operand whatever was configured
   a_operand_known: assert property (
      @(posedge clk) disable iff (!arst_n)
      !$isunknown(tracks) |-> !$isunknown(operand)
   ) else $error("connect_box: unknown operand with known tracks");

endmodule

//--- rtl/cgra_pkg.sv
`include "cgra_params.svh"

package cgra_pkg;

   // One bit per routing track of a side
   typedef struct packed {
      logic track3;
      logic track2;
      logic track1;
      logic track0;
   } side_tracks_t;

   typedef struct packed {
      side_tracks_t side3;
      side_tracks_t side2;
      side_tracks_t side1;
      side_tracks_t side0;
   } tile_tracks_t;

   typedef struct packed {
      logic [`CFG_W-`TILE_ID_W-1:0] feature;   // Target block code
      logic [`TILE_ID_W-1:0]        tile;
   } config_addr_t;

   // ####################
   // Config word views
   // ####################
   typedef struct packed {
      logic [`CFG_W-`SEL_W-1:0] rsvd;
      logic [`SEL_W-1:0]        track_sel;
   } cb_cfg_t;

   // Indexed [side][track]
   typedef struct packed {
      logic [`NUM_SIDES-1:0][`NUM_TRACKS-1:0][`SEL_W-1:0] route;
   } sb_cfg_t;

   typedef struct packed {
      logic [`CFG_W-`LUT_SIZE-2:0] rsvd;
      logic                        reg_en;
      logic [`LUT_SIZE-1:0]        lut;  // Indexed by {operand1, operand0}
   } clb_cfg_t;

   typedef union packed {
      cb_cfg_t  cb_cfg;
      sb_cfg_t  sb_cfg;
      clb_cfg_t clb_cfg;
   } config_word_u;

endpackage

//--- include/cgra_params.svh
`ifndef CGRA_PARAMS_SVH
`define CGRA_PARAMS_SVH

// ####################
// Tile geometry
// ####################
`define NUM_SIDES   4
`define NUM_TRACKS  4

// Configuration bus
`define CFG_W       32
`define TILE_ID_W   16
`define SEL_W       2       // Track and route select width
`define LUT_SIZE    4       // 2-input table

// ####################
// Feature codes
// ####################
`define FEAT_CB0    4
`define FEAT_CB1    5
`define FEAT_SB     6
`define FEAT_CLB    7

// Route select that picks the logic block result
`define SEL_CLB     3

`endif
